// ==== sources.f ====
+incdir+verification
design/dmem_pkg.sv
design/store_align.sv
design/byte_lane_ram.sv
design/load_extend.sv
design/data_mem_unit.sv
verification/tb_data_mem_unit.sv

// ==== verification/dmem_model.svh ====
`ifndef dmem_model_svh
`define dmem_model_svh

// Byte-addressed image of the 64-word window, indexed by addr[7:0]
logic [7:0] model_mem [0:255];

// Window rule, top nibble is 0001 or 0011
function automatic logic in_window(input logic [31:0] a);
  return (a[31:28] == 4'b0001) || (a[31:28] == 4'b0011);
endfunction

task automatic store_bytes(input logic [31:0] a, input logic [31:0] d, input mem_func_e f);
  logic [7:0] base;
  base = a[7:0];
  if (in_window(a)) begin
    case (f)
      func_byte: model_mem[base] = d[7:0];
      func_half: begin
        base[0] = 1'b0; // Halfword aligned
        model_mem[base]      = d[7:0];
        model_mem[base + 1]  = d[15:8];
      end
      func_word: begin
        base[1:0] = 2'b00;
        for (int i = 0; i < 4; i++) begin
          model_mem[base + i] = d[8*i +: 8];
        end
      end
      default: ;
    endcase
  end
endtask

// Expected load result, zero outside the window
function automatic logic [31:0] load_value(input logic [31:0] a, input mem_func_e f);
  logic [7:0]  b;
  logic [15:0] h;
  logic [31:0] w;
  b = model_mem[a[7:0]];
  h = {model_mem[{a[7:1], 1'b1}], model_mem[{a[7:1], 1'b0}]};
  w = {model_mem[{a[7:2], 2'b11}], model_mem[{a[7:2], 2'b10}],
       model_mem[{a[7:2], 2'b01}], model_mem[{a[7:2], 2'b00}]};
  if (!in_window(a)) return 32'h0;
  case (f)
    func_byte:   return {{24{b[7]}}, b};
    func_byte_u: return {24'h0, b};
    func_half:   return {{16{h[15]}}, h};
    func_half_u: return {16'h0, h};
    func_word:   return w;
    default:     return 32'h0;
  endcase
endfunction

`endif

// ==== verification/tb_data_mem_unit.sv ====
`timescale 1ns/100ps

module tb_data_mem_unit;

  import dmem_pkg::*;

  localparam int dmem_awidth    = 6;
  localparam int timeout_cycles = 20;

  logic        clk;
  logic        rst_n;
  logic [31:0] addr;
  logic [31:0] wdata;
  mem_func_e   func;
  logic        we;
  logic        re;
  logic [31:0] rdata;
  logic        rdata_valid;

  integer      seed;
  int          error_count;
  int          read_count;
  int          valid_count;
  logic        valid_due;   // A read was strobed in the previous cycle
  logic [31:0] expect_q [$];

  `include "dmem_model.svh"

  data_mem_unit #(
    .dmem_awidth(dmem_awidth)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr       (addr),
    .wdata      (wdata),
    .func       (func),
    .we         (we),
    .re         (re),
    .rdata      (rdata),
    .rdata_valid(rdata_valid)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected,
               $time);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      check_value("rdata_valid", rdata_valid, valid_due);
      if (rdata_valid === 1'b1) begin
        valid_count++;
        if (expect_q.size() == 0) begin
          error_count++;
          $display("Unexpected rdata_valid pulse with no read pending at %0t", $time);
        end else begin
          check_value("rdata", rdata, expect_q.pop_front());
        end
      end
      valid_due = re;
    end
  end

  function automatic logic [31:0] pick_addr(input logic hit);
    logic [31:0] a;
    a = $random(seed);
    if (hit) begin
      a[31:28] = {2'b00, a[29], 1'b1};
    end else if (in_window(a)) begin
      a[31] = 1'b1; // Push it out of the window
    end
    return a;
  endfunction

  function automatic mem_func_e pick_store_func();
    case ($unsigned($random(seed)) % 3)
      0:       return func_byte;
      1:       return func_half;
      default: return func_word;
    endcase
  endfunction

  function automatic mem_func_e pick_load_func();
    case ($unsigned($random(seed)) % 5)
      0:       return func_byte;
      1:       return func_half;
      2:       return func_word;
      3:       return func_byte_u;
      default: return func_half_u;
    endcase
  endfunction

  function automatic mem_func_e pick_narrow_load();
    case ($unsigned($random(seed)) % 4)
      0:       return func_byte;
      1:       return func_byte_u;
      2:       return func_half;
      default: return func_half_u;
    endcase
  endfunction

  task automatic issue_write(input logic [31:0] a, input logic [31:0] d, input mem_func_e f);
    @(posedge clk);
    addr  <= a;
    wdata <= d;
    func  <= f;
    we    <= 1'b1;
    re    <= 1'b0;
    store_bytes(a, d, f);
  endtask

  task automatic issue_read(input logic [31:0] a, input mem_func_e f);
    @(posedge clk);
    addr <= a;
    func <= f;
    we   <= 1'b0;
    re   <= 1'b1;
    expect_q.push_back(load_value(a, f));
    read_count++;
  endtask

  task automatic go_idle();
    @(posedge clk);
    we <= 1'b0;
    re <= 1'b0;
  endtask

  task automatic wait_reads_done();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("Timeout: %0d read(s) never got rdata_valid", expect_q.size());
      $display("Errors: %0d, reads: %0d, valid pulses: %0d", error_count, read_count,
               valid_count);
      $display("Result: FAILED");
      $finish;
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] r;
    seed        = 64101;
    clk         = 1'b0;
    rst_n       = 1'b0;
    addr        = '0;
    wdata       = '0;
    func        = func_word;
    we          = 1'b0;
    re          = 1'b0;
    error_count = 0;
    read_count  = 0;
    valid_count = 0;
    valid_due   = 1'b0;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet outputs after reset
    @(negedge clk);
    check_value("rdata_valid", rdata_valid, 32'h0);
    check_value("rdata", rdata, 32'h0);

    // Fill every word, then word stores and loads
    for (int w = 0; w < 64; w++) begin
      issue_write({4'b0001, 20'h0, 6'(w), 2'b00}, $random(seed), func_word);
    end
    repeat (40) begin
      a = pick_addr(1'b1);
      issue_write(a, $random(seed), func_word);
      issue_read(a, func_word);
      go_idle();
      wait_reads_done();
    end

    // Narrow stores and extended loads
    repeat (60) begin
      a = pick_addr(1'b1);
      issue_write(a, $random(seed), ($random(seed) & 1) ? func_half : func_byte);
      issue_read(a, pick_narrow_load());
      go_idle();
      wait_reads_done();
    end

    // Misses, then the in-window alias must be untouched
    repeat (20) begin
      a = pick_addr(1'b0);
      issue_write(a, $random(seed), pick_store_func());
      issue_read(a, pick_load_func());
      issue_read({4'b0001, a[27:0]}, func_word);
      go_idle();
      wait_reads_done();
    end

    // Back-to-back random traffic
    repeat (400) begin
      r = $random(seed);
      a = pick_addr(r[4:2] != 3'b000); // Mostly hits
      if (r[1:0] == 2'b00) begin
        go_idle();
      end else if (r[1]) begin
        issue_read(a, pick_load_func());
      end else begin
        issue_write(a, $random(seed), pick_store_func());
      end
    end
    go_idle();
    wait_reads_done();

    check_value("valid_count", valid_count, read_count);
    $display("Errors: %0d, reads: %0d, valid pulses: %0d", error_count, read_count,
             valid_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== design/data_mem_unit.sv ====
`timescale 1ns/100ps

module data_mem_unit #(
  parameter int dmem_awidth = 14
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [dmem_pkg::addr_width-1:0] addr,
  input  logic [dmem_pkg::data_width-1:0] wdata,
  input  dmem_pkg::mem_func_e             func,
  input  logic                            we,
  input  logic                            re,
  output logic [dmem_pkg::data_width-1:0] rdata,
  output logic                            rdata_valid
);

  import dmem_pkg::*;

  logic [data_width-1:0]  lane_wdata;
  logic [num_lanes-1:0]   lane_we;
  logic [data_width-1:0]  lane_rdata;
  logic                   region_hit;
  logic [dmem_awidth-1:0] word_addr;

  // Word index sits right above the byte offset
  // Bits between it and the top nibble are don't-care
  assign word_addr = addr[2 +: dmem_awidth];

  store_align store_align_i (
    .addr      (addr),
    .wdata     (wdata),
    .func      (func),
    .we        (we),
    .lane_wdata(lane_wdata),
    .lane_we   (lane_we),
    .region_hit(region_hit)
  );

  // One RAM per byte lane on the shared word index
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    byte_lane_ram #(
      .dmem_awidth(dmem_awidth)
    ) lane_i (
      .clk      (clk),
      .word_addr(word_addr),
      .wdata    (lane_wdata[i*lane_width +: lane_width]),
      .we       (lane_we[i]),
      .rdata    (lane_rdata[i*lane_width +: lane_width])
    );
  end

  load_extend load_extend_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .re         (re),
    .region_hit (region_hit),
    .offset     (addr[1:0]),
    .func       (func),
    .lane_rdata (lane_rdata),
    .rdata      (rdata),
    .rdata_valid(rdata_valid)
  );

  // A read and a write never share a cycle
  a_no_rw_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(we && re)
  ) else $error("data_mem_unit: we and re high in the same cycle");

endmodule

// ==== design/load_extend.sv ====
`timescale 1ns/100ps

module load_extend (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            re,
  input  logic                            region_hit,
  input  logic [1:0]                      offset,
  input  dmem_pkg::mem_func_e             func,
  input  logic [dmem_pkg::data_width-1:0] lane_rdata,
  output logic [dmem_pkg::data_width-1:0] rdata,
  output logic                            rdata_valid
);

  import dmem_pkg::*;

  logic                  re_q;      // Read issued last cycle
  logic                  hit_q;     // ...and it was inside the window
  logic [1:0]            offset_q;
  mem_func_e             func_q;
  logic [data_width-1:0] byte_shift;
  logic [data_width-1:0] half_shift;
  logic [lane_width-1:0] byte_val;
  logic [2*lane_width-1:0] half_val;
  logic [data_width-1:0] load_data;

  // Lanes answer one cycle late, so the controls wait with them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      re_q     <= 1'b0;
      hit_q    <= 1'b0;
      offset_q <= 2'b00;
      func_q   <= func_word;
    end else begin
      re_q     <= re;
      hit_q    <= re && region_hit;
      offset_q <= offset;
      func_q   <= func;
    end
  end

  // Move the addressed byte or halfword down to bit 0
  assign byte_shift = lane_rdata >> {offset_q, 3'b000};
  assign half_shift = lane_rdata >> {offset_q[1], 4'b0000}; // Halfword aligned
  assign byte_val   = byte_shift[lane_width-1:0];
  assign half_val   = half_shift[2*lane_width-1:0];

  always_comb begin
    case (func_q)
      func_byte:   load_data = {{(data_width-lane_width){byte_val[lane_width-1]}}, byte_val};
      func_byte_u: load_data = {{(data_width-lane_width){1'b0}}, byte_val};
      func_half:   load_data = {{(data_width-2*lane_width){half_val[2*lane_width-1]}},
                                half_val};
      func_half_u: load_data = {{(data_width-2*lane_width){1'b0}}, half_val};
      func_word:   load_data = lane_rdata;
      default:     load_data = '0;
    endcase
  end

  // Misses and idle cycles read as zero
  assign rdata       = hit_q ? load_data : '0;
  assign rdata_valid = re_q;

  // Returned data must belong to a real load code
  a_valid_func: assert property (
    @(posedge clk) disable iff (!rst_n)
    rdata_valid |-> func_q inside {func_byte, func_half, func_word, func_byte_u, func_half_u}
  ) else $error("load_extend: valid load with bad function code %0d", func_q);

endmodule

// ==== design/byte_lane_ram.sv ====
`timescale 1ns/100ps

module byte_lane_ram #(
  parameter int dmem_awidth = 14
) (
  input  logic                            clk,
  input  logic [dmem_awidth-1:0]          word_addr,
  input  logic [dmem_pkg::lane_width-1:0] wdata,
  input  logic                            we,
  output logic [dmem_pkg::lane_width-1:0] rdata
);

  import dmem_pkg::*;

  logic [lane_width-1:0] mem [0:(1 << dmem_awidth)-1];

  // Write and registered read share the address
  // A same-cycle write shows up on rdata only on the next access
  always_ff @(posedge clk) begin
    if (we) begin
      mem[word_addr] <= wdata;
    end
    rdata <= mem[word_addr];
  end

endmodule

// ==== design/store_align.sv ====
`timescale 1ns/100ps

module store_align (
  input  logic [dmem_pkg::addr_width-1:0] addr,
  input  logic [dmem_pkg::data_width-1:0] wdata,
  input  dmem_pkg::mem_func_e             func,
  input  logic                            we,
  output logic [dmem_pkg::data_width-1:0] lane_wdata,
  output logic [dmem_pkg::num_lanes-1:0]  lane_we,
  output logic                            region_hit
);

  import dmem_pkg::*;

  logic [num_lanes-1:0] lane_mask; // Lanes touched by this access size

  // Window decode, done once here and shared with the load side
  assign region_hit = ((addr[addr_width-1 -: 4] & region_mask) == region_match);

  // Replicate the store data so every lane sees its byte, then pick lanes
  always_comb begin
    lane_wdata = '0;
    lane_mask  = '0;
    case (func)
      func_byte: begin
        lane_wdata = {num_lanes{wdata[lane_width-1:0]}};
        lane_mask  = num_lanes'(1) << addr[1:0];
      end
      func_half: begin
        // Halfword sits in lanes 0-1 or 2-3, addr[0] ignored
        lane_wdata = {(num_lanes/2){wdata[2*lane_width-1:0]}};
        lane_mask  = num_lanes'(3) << {addr[1], 1'b0};
      end
      func_word: begin
        lane_wdata = wdata; // Offset ignored
        lane_mask  = '1;
      end
      default: begin
        lane_wdata = '0;    // Load-only codes write nothing
        lane_mask  = '0;
      end
    endcase
  end

  // No lane is written outside the window
  assign lane_we = (we && region_hit) ? lane_mask : '0;

  // A store must come with sb, sh or sw
  always_comb begin
    if (we) begin
      assert #0 (func inside {func_byte, func_half, func_word})
        else $error("store_align: store with load-only function code %0d", func);
    end
  end

endmodule

// ==== design/dmem_pkg.sv ====
package dmem_pkg;

  // Bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int lane_width = 8;
  localparam int num_lanes  = data_width / lane_width; // One lane per byte

  // Data memory window
  // Top address nibble with bit 29 masked off must read 0001
  localparam logic [3:0] region_mask  = 4'b1101;
  localparam logic [3:0] region_match = 4'b0001;

  // Memory access function code, same encoding as funct3 of loads and stores
  // Stores only use the signed byte, half and word codes
  typedef enum logic [2:0] {
    func_byte   = 3'd0, // lb / sb
    func_half   = 3'd1, // lh / sh
    func_word   = 3'd2, // lw / sw
    func_byte_u = 3'd4, // lbu
    func_half_u = 3'd5  // lhu
  } mem_func_e;

endpackage
